// File: hdl/hdc_consts.svh
`ifndef HDC_CONSTS_SVH
`define HDC_CONSTS_SVH

// hypervector geometry
`define HDC_DIM             64
`define HDC_ITEMS           16
`define HDC_ITEM_AW         4

// program store
`define HDC_PROG_DEPTH      32
`define HDC_PC_W            5

// register map
`define HDC_REG_CTRL        2'd0
`define HDC_REG_SEED        2'd1
`define HDC_REG_LEN         2'd2

// control register bits
`define HDC_CTRL_START_BIT  0
`define HDC_CTRL_GEN_BIT    1

`endif

// File: hdl/hdc_pkg.sv
`default_nettype none

`include "hdc_consts.svh"

package hdc_pkg;

    // opcodes, the loaded forms take an item address
    typedef enum logic [3:0] {
        op_nop        = 4'd0,
        op_load       = 4'd1,
        op_lrot_r     = 4'd2,
        op_lrot_l     = 4'd3,
        op_lxor       = 4'd4,
        op_wb         = 4'd5,
        op_rot_r      = 4'd6,
        op_rot_l      = 4'd7,
        op_xor        = 4'd8,
        op_store      = 4'd9,
        op_last_store = 4'd10,
        op_move       = 4'd11
    } hdc_op_e;

    typedef enum logic [1:0] {
        seq_idle,
        seq_fetch,
        seq_issue,
        seq_drain
    } seq_state_e;

    typedef struct packed {
        hdc_op_e                 op;
        logic [`HDC_ITEM_AW-1:0] addr;
    } hdc_instr_t;

    typedef struct packed {
        logic                    en;
        logic [`HDC_ITEM_AW-1:0] addr;
        logic [`HDC_DIM-1:0]     data;
    } hdc_mem_wr_t;

    typedef struct packed {
        logic                valid;
        logic                last;
        logic [`HDC_DIM-1:0] data;
    } hdc_result_t;

    // start and gen are single-cycle pulses
    typedef struct packed {
        logic [`HDC_DIM-1:0]  seed;
        logic [`HDC_PC_W-1:0] prog_len;
        logic                 start;
        logic                 gen;
    } hdc_cfg_t;

endpackage

`default_nettype wire

// File: hdl/hdc_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_cfg_regs (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  reg_we,
    input  wire [1:0]            reg_addr,
    input  wire [`HDC_DIM-1:0]   reg_wdata,
    input  wire                  gen_busy,
    input  wire                  done_pulse,
    output hdc_pkg::hdc_cfg_t    cfg,
    output logic                 busy,
    output logic                 done
);

    logic ctrl_we;
    logic idle;
    logic start_ok;
    logic gen_ok;

    assign ctrl_we = reg_we && (reg_addr == `HDC_REG_CTRL);

    // nothing running, generating, or about to generate
    assign idle = !busy && !gen_busy && !cfg.gen;

    assign gen_ok = ctrl_we && idle && reg_wdata[`HDC_CTRL_GEN_BIT];

    // generate takes precedence when both bits come in one write
    assign start_ok = ctrl_we && idle && reg_wdata[`HDC_CTRL_START_BIT]
                      && !reg_wdata[`HDC_CTRL_GEN_BIT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg  <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            cfg.start <= start_ok;
            cfg.gen   <= gen_ok;

            if (reg_we && (reg_addr == `HDC_REG_SEED)) begin
                cfg.seed <= reg_wdata;
            end
            if (reg_we && (reg_addr == `HDC_REG_LEN)) begin
                cfg.prog_len <= reg_wdata[`HDC_PC_W-1:0];
            end

            // done holds until the next accepted start
            if (start_ok) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (done_pulse) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/hdc_item_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_item_gen (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire hdc_pkg::hdc_cfg_t cfg,
    output hdc_pkg::hdc_mem_wr_t  gen_wr,
    output logic                  gen_busy
);

    logic [`HDC_DIM-1:0]     state_q;
    logic [`HDC_DIM-1:0]     state_next;
    logic [`HDC_ITEM_AW-1:0] slot_q;

    // one xorshift step: <<13, >>7, <<17
    function automatic logic [`HDC_DIM-1:0] xorshift(input logic [`HDC_DIM-1:0] v);
        logic [`HDC_DIM-1:0] t;
        t = v ^ (v << 13);
        t = t ^ (t >> 7);
        t = t ^ (t << 17);
        return t;
    endfunction

    assign state_next = xorshift(state_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gen_busy <= 1'b0;
            slot_q   <= '0;
        end else if (cfg.gen) begin
            gen_busy <= 1'b1;
            slot_q   <= '0;
        end else if (gen_busy) begin
            slot_q <= slot_q + `HDC_ITEM_AW'd1;
            // slot count is a power of two, so all ones is the last slot
            if (&slot_q) begin
                gen_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cfg.gen) begin
            state_q <= cfg.seed;
        end else if (gen_busy) begin
            state_q <= state_next;
        end
    end

    // slot i gets seed advanced i+1 steps
    always_comb begin
        gen_wr.en   = gen_busy;
        gen_wr.addr = slot_q;
        gen_wr.data = state_next;
    end

endmodule

`default_nettype wire

// File: hdl/hdc_item_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_item_memory (
    input  wire                          clk,
    input  wire hdc_pkg::hdc_mem_wr_t    wr,
    input  wire [`HDC_ITEM_AW-1:0]       rd_addr,
    output logic [`HDC_DIM-1:0]          rd_data
);

    logic [`HDC_DIM-1:0] mem [`HDC_ITEMS];

    // write port, shared upstream between generator and write-back
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hdl/hdc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_sequencer (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire hdc_pkg::hdc_cfg_t   cfg,
    input  wire                      prog_we,
    input  wire [`HDC_PC_W-1:0]      prog_addr,
    input  wire hdc_pkg::hdc_instr_t prog_wdata,
    output logic                     instr_valid,
    output hdc_pkg::hdc_instr_t      instr,
    output logic                     done_pulse
);

    import hdc_pkg::*;

    hdc_instr_t           prog_mem [`HDC_PROG_DEPTH];
    seq_state_e           state_q;
    logic [`HDC_PC_W-1:0] pc_q;
    logic [`HDC_PC_W-1:0] pc_next;
    logic [`HDC_PC_W-1:0] len_q;

    assign pc_next = pc_q + `HDC_PC_W'd1;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_wdata;
        end
    end

    // registered read straight into the issue register
    always_ff @(posedge clk) begin
        instr <= prog_mem[pc_q];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= seq_idle;
            pc_q        <= '0;
            len_q       <= '0;
            instr_valid <= 1'b0;
            done_pulse  <= 1'b0;
        end else begin
            done_pulse <= 1'b0;
            unique case (state_q)
                seq_idle: begin
                    instr_valid <= 1'b0;
                    if (cfg.start) begin
                        state_q <= seq_fetch;
                        pc_q    <= '0;
                        len_q   <= cfg.prog_len;
                    end
                end
                // fetch covers word 0, issue the rest back to back
                seq_fetch, seq_issue: begin
                    if (len_q == '0) begin
                        instr_valid <= 1'b0;
                        state_q     <= seq_drain;
                    end else begin
                        instr_valid <= 1'b1;
                        pc_q        <= pc_next;
                        if (pc_next == len_q) begin
                            state_q <= seq_drain;
                        end else begin
                            state_q <= seq_issue;
                        end
                    end
                end
                // last word is in flight
                // pulse lands so done rises on its execute edge
                seq_drain: begin
                    instr_valid <= 1'b0;
                    done_pulse  <= 1'b1;
                    state_q     <= seq_idle;
                end
                default: begin
                    state_q <= seq_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/hdc_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_core (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start,
    input  wire                      instr_valid,
    input  wire hdc_pkg::hdc_instr_t instr,
    output logic [`HDC_ITEM_AW-1:0]  rd_addr,
    input  wire [`HDC_DIM-1:0]       rd_data,
    output hdc_pkg::hdc_mem_wr_t     wb_wr,
    output hdc_pkg::hdc_result_t     result
);

    import hdc_pkg::*;

    // stage one
    logic                    s1_valid;
    hdc_op_e                 s1_op;
    logic [`HDC_ITEM_AW-1:0] s1_addr;
    logic                    s1_fwd;
    logic [`HDC_DIM-1:0]     s1_fwd_data;
    logic [`HDC_DIM-1:0]     operand;

    // stage two
    logic [`HDC_DIM-1:0]     acc_q;
    logic [`HDC_DIM-1:0]     hold_q;
    logic                    res_valid_q;
    logic                    res_last_q;
    logic [`HDC_DIM-1:0]     res_data_q;

    // memory sees the issued address on the next edge
    assign rd_addr = instr.addr;

    // write-back goes to memory on the execute edge
    always_comb begin
        wb_wr.en   = s1_valid && (s1_op == op_wb);
        wb_wr.addr = s1_addr;
        wb_wr.data = acc_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= instr_valid;
        end
    end

    // catch a write-back landing on the same edge as our read
    always_ff @(posedge clk) begin
        s1_op       <= instr.op;
        s1_addr     <= instr.addr;
        s1_fwd      <= wb_wr.en && (wb_wr.addr == instr.addr);
        s1_fwd_data <= wb_wr.data;
    end

    assign operand = s1_fwd ? s1_fwd_data : rd_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q       <= '0;
            hold_q      <= '0;
            res_valid_q <= 1'b0;
            res_last_q  <= 1'b0;
        end else begin
            res_valid_q <= 1'b0;
            res_last_q  <= 1'b0;
            if (start) begin
                acc_q  <= '0;
                hold_q <= '0;
            end else if (s1_valid) begin
                unique case (s1_op)
                    op_load:   acc_q <= operand;
                    op_lrot_r: acc_q <= {operand[0], operand[`HDC_DIM-1:1]};
                    op_lrot_l: acc_q <= {operand[`HDC_DIM-2:0], operand[`HDC_DIM-1]};
                    op_lxor:   acc_q <= operand ^ acc_q;
                    op_rot_r:  acc_q <= {acc_q[0], acc_q[`HDC_DIM-1:1]};
                    op_rot_l:  acc_q <= {acc_q[`HDC_DIM-2:0], acc_q[`HDC_DIM-1]};
                    op_xor:    acc_q <= hold_q ^ acc_q;
                    op_move:   hold_q <= acc_q;
                    op_store: begin
                        res_valid_q <= 1'b1;
                    end
                    op_last_store: begin
                        res_valid_q <= 1'b1;
                        res_last_q  <= 1'b1;
                    end
                    // write-back handled combinationally above
                    op_nop, op_wb: begin
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid && ((s1_op == op_store) || (s1_op == op_last_store))) begin
            res_data_q <= acc_q;
        end
    end

    assign result = '{valid: res_valid_q, last: res_last_q, data: res_data_q};

endmodule

`default_nettype wire

// File: hdl/hdc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      reg_we,
    input  wire [1:0]                reg_addr,
    input  wire [`HDC_DIM-1:0]       reg_wdata,
    input  wire                      prog_we,
    input  wire [`HDC_PC_W-1:0]      prog_addr,
    input  wire hdc_pkg::hdc_instr_t prog_wdata,
    output logic                     busy,
    output logic                     done,
    output hdc_pkg::hdc_result_t     result
);

    import hdc_pkg::*;

    hdc_cfg_t                cfg;
    hdc_mem_wr_t             gen_wr;
    hdc_mem_wr_t             wb_wr;
    hdc_mem_wr_t             mem_wr;
    hdc_instr_t              instr;
    logic                    gen_busy;
    logic                    done_pulse;
    logic                    instr_valid;
    logic [`HDC_ITEM_AW-1:0] rd_addr;
    logic [`HDC_DIM-1:0]     rd_data;

    // programs never run during generation, so one writer at a time
    assign mem_wr = gen_busy ? gen_wr : wb_wr;

    hdc_cfg_regs u_cfg_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_we     (reg_we),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .gen_busy   (gen_busy),
        .done_pulse (done_pulse),
        .cfg        (cfg),
        .busy       (busy),
        .done       (done)
    );

    hdc_item_gen u_item_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .gen_wr   (gen_wr),
        .gen_busy (gen_busy)
    );

    hdc_item_memory u_item_memory (
        .clk     (clk),
        .wr      (mem_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    hdc_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_wdata  (prog_wdata),
        .instr_valid (instr_valid),
        .instr       (instr),
        .done_pulse  (done_pulse)
    );

    hdc_core u_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (cfg.start),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .wb_wr       (wb_wr),
        .result      (result)
    );

endmodule

`default_nettype wire

// File: tests/hdc_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_asserts (
    input wire                       clk,
    input wire                       rst_n,
    input wire                       busy,
    input wire                       done,
    input wire hdc_pkg::hdc_result_t result,
    input wire hdc_pkg::hdc_cfg_t    cfg,
    input wire                       gen_busy,
    input wire                       done_pulse
);

    // quiet when reset lets go
    reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !busy && !done && !result.valid && !result.last && !gen_busy)
        else $error("outputs active right after reset");

    busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done))
        else $error("busy and done high together");

    last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        result.last |-> result.valid)
        else $error("result last without result valid");

    // final store lands in the cycle done rises
    valid_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        result.valid |-> busy || $rose(done))
        else $error("result valid while idle");

    start_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        cfg.start |=> !cfg.start)
        else $error("start pulse longer than one cycle");

    gen_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        cfg.gen |=> !cfg.gen)
        else $error("generate pulse longer than one cycle");

    gen_busy_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(gen_busy && busy) && !(cfg.start && cfg.gen))
        else $error("generation overlaps a program run");

    done_pulse_width: assert property (@(posedge clk) disable iff (!rst_n)
        done_pulse |=> !done_pulse)
        else $error("done pulse longer than one cycle");

endmodule

bind hdc_top hdc_asserts u_hdc_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .busy       (busy),
    .done       (done),
    .result     (result),
    .cfg        (cfg),
    .gen_busy   (gen_busy),
    .done_pulse (done_pulse)
);

`default_nettype wire

// File: tests/hdc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_tb;

    import hdc_pkg::*;

    // whole run is a few hundred cycles, this leaves wide margin
    localparam int MAX_CYCLES = 2000;

    logic                 clk;
    logic                 rst_n;
    logic                 reg_we;
    logic [1:0]           reg_addr;
    logic [`HDC_DIM-1:0]  reg_wdata;
    logic                 prog_we;
    logic [`HDC_PC_W-1:0] prog_addr;
    hdc_instr_t           prog_wdata;
    logic                 busy;
    logic                 done;
    hdc_result_t          result;

    logic [31:0]          lcg_state;
    int                   cycle_count = 0;
    int                   value_errors;
    int                   other_errors;
    hdc_instr_t           prog [$];
    logic [`HDC_DIM-1:0]  exp_data [$];
    logic                 exp_last [$];
    logic [`HDC_DIM-1:0]  model_mem [`HDC_ITEMS];
    logic [`HDC_DIM-1:0]  seed;
    int                   slot_a;
    int                   slot_b;

    hdc_top u_hdc_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_we     (reg_we),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata),
        .busy       (busy),
        .done       (done),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`HDC_DIM-1:0] xorshift_step(input logic [`HDC_DIM-1:0] v);
        logic [`HDC_DIM-1:0] x;
        x = v;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic logic [`HDC_DIM-1:0] rotate_right(input logic [`HDC_DIM-1:0] v);
        return (v >> 1) | (v << (`HDC_DIM - 1));
    endfunction

    function automatic logic [`HDC_DIM-1:0] rotate_left(input logic [`HDC_DIM-1:0] v);
        return (v << 1) | (v >> (`HDC_DIM - 1));
    endfunction

    function automatic void emit(input hdc_op_e op, input int a);
        hdc_instr_t w;
        w.op   = op;
        w.addr = `HDC_ITEM_AW'(a);
        prog.push_back(w);
    endfunction

    // reference core, walks the program in order
    function automatic void model_exec();
        logic [`HDC_DIM-1:0] acc;
        logic [`HDC_DIM-1:0] hold;
        acc  = '0;
        hold = '0;
        foreach (prog[i]) begin
            case (prog[i].op)
                op_load:   acc = model_mem[prog[i].addr];
                op_lrot_r: acc = rotate_right(model_mem[prog[i].addr]);
                op_lrot_l: acc = rotate_left(model_mem[prog[i].addr]);
                op_lxor:   acc = acc ^ model_mem[prog[i].addr];
                op_wb:     model_mem[prog[i].addr] = acc;
                op_rot_r:  acc = rotate_right(acc);
                op_rot_l:  acc = rotate_left(acc);
                op_xor:    acc = acc ^ hold;
                op_move:   hold = acc;
                op_store, op_last_store: begin
                    exp_data.push_back(acc);
                    exp_last.push_back(prog[i].op == op_last_store);
                end
                default: begin
                end
            endcase
        end
    endfunction

    task automatic reg_write(input logic [1:0] a, input logic [`HDC_DIM-1:0] d);
        reg_we    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(negedge clk);
        reg_we    = 1'b0;
    endtask

    task automatic write_program();
        for (int i = 0; i < prog.size(); i++) begin
            prog_we    = 1'b1;
            prog_addr  = `HDC_PC_W'(i);
            prog_wdata = prog[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
    endtask

    task automatic generate_items(input logic [`HDC_DIM-1:0] s);
        logic [`HDC_DIM-1:0] x;
        x = s;
        for (int i = 0; i < `HDC_ITEMS; i++) begin
            x = xorshift_step(x);
            model_mem[i] = x;
        end
        reg_write(`HDC_REG_SEED, s);
        reg_write(`HDC_REG_CTRL, 64'd1 << `HDC_CTRL_GEN_BIT);
        // one slot per cycle, fixed length
        repeat (`HDC_ITEMS + 2) @(negedge clk);
    endtask

    task automatic run_program(input string name, input bit poke_ctrl);
        int                  cycles;
        int                  rises;
        int                  after_done;
        logic                done_prev;
        logic [`HDC_DIM-1:0] want;
        logic                want_last;
        write_program();
        reg_write(`HDC_REG_LEN, 64'(prog.size()));
        model_exec();
        reg_write(`HDC_REG_CTRL, 64'd1 << `HDC_CTRL_START_BIT);
        cycles     = 0;
        rises      = 0;
        after_done = 0;
        done_prev  = done;
        while (after_done < 3 && cycles < prog.size() + 16) begin
            // generate then start while busy, both must be dropped
            if (poke_ctrl && cycles == 1) begin
                reg_we    = 1'b1;
                reg_addr  = `HDC_REG_CTRL;
                reg_wdata = 64'd1 << `HDC_CTRL_GEN_BIT;
            end else if (poke_ctrl && cycles == 2) begin
                reg_wdata = 64'd1 << `HDC_CTRL_START_BIT;
            end else begin
                reg_we = 1'b0;
            end
            if (result.valid) begin
                assert (exp_data.size() > 0) else begin
                    other_errors++;
                    $display("%s: a result came out that the program does not produce", name);
                end
                if (exp_data.size() > 0) begin
                    want      = exp_data.pop_front();
                    want_last = exp_last.pop_front();
                    assert (result.data == want) else begin
                        value_errors++;
                        $display("[FAIL] %s: data expected %h, actual %h",
                                 name, want, result.data);
                    end
                    assert (result.last == want_last) else begin
                        value_errors++;
                        $display("[FAIL] %s: last expected %0b, actual %0b",
                                 name, want_last, result.last);
                    end
                end
            end
            if (done && !done_prev) begin
                rises++;
            end
            if (done) begin
                after_done++;
            end
            done_prev = done;
            @(negedge clk);
            cycles++;
        end
        reg_we = 1'b0;
        assert (rises == 1) else begin
            other_errors++;
            $display("%s: done rose %0d times instead of once", name, rises);
        end
        assert (exp_data.size() == 0) else begin
            other_errors++;
            $display("%s: %0d expected results never appeared", name, exp_data.size());
        end
        assert (done && !busy) else begin
            other_errors++;
            $display("%s: still busy or not done at the end of the program", name);
        end
        exp_data.delete();
        exp_last.delete();
        prog.delete();
    endtask

    initial begin
        rst_n        = 1'b0;
        reg_we       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_wdata   = '0;
        lcg_state    = 32'hdeebb6a0;
        value_errors = 0;
        other_errors = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        assert (!busy && !done && !result.valid) else begin
            other_errors++;
            $display("outputs are not idle after reset");
        end
        // length is still zero after reset
        run_program("empty_start", 1'b0);

        seed = {lcg_next(), lcg_next()};
        generate_items(seed);
        for (int s = 0; s < 8; s++) begin
            emit(op_load, s);
            emit(s == 7 ? op_last_store : op_store, 0);
        end
        run_program("load_store_low", 1'b0);
        for (int s = 8; s < `HDC_ITEMS; s++) begin
            emit(op_load, s);
            emit(s == `HDC_ITEMS - 1 ? op_last_store : op_store, 0);
        end
        run_program("load_store_high", 1'b0);

        slot_a = int'(lcg_next() % `HDC_ITEMS);
        slot_b = int'(lcg_next() % `HDC_ITEMS);
        emit(op_lrot_r, slot_a);
        emit(op_store, 0);
        emit(op_lrot_l, slot_b);
        emit(op_store, 0);
        emit(op_rot_l, 0);
        emit(op_store, 0);
        emit(op_rot_r, 0);
        emit(op_rot_r, 0);
        emit(op_last_store, 0);
        run_program("rotate", 1'b0);

        emit(op_load, slot_a);
        emit(op_move, 0);
        emit(op_lxor, slot_b);
        emit(op_store, 0);
        emit(op_xor, 0);
        emit(op_last_store, 0);
        run_program("bind", 1'b0);

        // load right behind the write-back hits the forward path
        emit(op_load, 6);
        emit(op_rot_l, 0);
        emit(op_wb, 12);
        emit(op_load, 12);
        emit(op_store, 0);
        emit(op_load, 3);
        emit(op_load, 12);
        emit(op_last_store, 0);
        run_program("writeback_forward", 1'b0);

        // a stray start would clear the loaded accumulator
        emit(op_load, slot_a);
        for (int i = 0; i < 6; i++) begin
            emit(op_nop, i);
        end
        emit(op_last_store, 0);
        run_program("busy_ignore", 1'b1);
        for (int i = 0; i < 4; i++) begin
            emit(op_nop, 0);
        end
        run_program("nops_only", 1'b0);
        // the same seed would regenerate the same items
        // only the written-back slot 12 shows a stray generate
        emit(op_load, 0);
        emit(op_store, 0);
        emit(op_load, 12);
        emit(op_last_store, 0);
        run_program("memory_kept", 1'b0);

        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+hdl
hdl/hdc_pkg.sv
hdl/hdc_cfg_regs.sv
hdl/hdc_item_gen.sv
hdl/hdc_item_memory.sv
hdl/hdc_sequencer.sv
hdl/hdc_core.sv
hdl/hdc_top.sv
tests/hdc_asserts.sv
tests/hdc_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= hdc_tb
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= TEST OK

SOURCES := $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
